//--- Makefile
# Verilator build for the trace replay project

VERILATOR := verilator
VFLAGS    := --binary --timing
LINTFLAGS := --lint-only --timing
TOP       := tb_dmc_replay
RTL_TOP   := dmc_replay_top
FILELIST  := dmc_replay.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- common/dmc_trace_pkg.sv
/*
  Trace and controller-interface definitions. Widths are fixed here, since the
  packed trace entry depends on them. A set mask bit enables its byte.
*/

`default_nettype none

package dmc_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH    = 32;
    localparam int MASK_WIDTH    = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH    = 10;
    localparam int PAYLOAD_WIDTH = DATA_WIDTH + MASK_WIDTH;

    // Controller commands in the low codes, trace-only codes above
    typedef enum logic [3:0] {
        WR  = 4'h0,
        RD  = 4'h1,
        RP  = 4'h2,
        WP  = 4'h3,
        TWD = 4'h8,
        TWT = 4'h9,
        TNP = 4'ha,
        TEX = 4'hf
    } app_cmd_e;

    ////////////////////////////////////////////////////////////////////////////
    // Trace entry
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [PAYLOAD_WIDTH-ADDR_WIDTH-1:0] pad;
        logic [ADDR_WIDTH-1:0]               addr;
    } cmd_payload_s;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [MASK_WIDTH-1:0] mask;
    } wdata_payload_s;

    typedef union packed {
        cmd_payload_s   cmd;
        wdata_payload_s wdata;
    } trace_payload_u;

    // 4-bit command over a 36-bit payload
    typedef struct packed {
        app_cmd_e       app_cmd;
        trace_payload_u payload;
    } trace_entry_s;

    ////////////////////////////////////////////////////////////////////////////
    // Controller user interface
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        app_cmd_e              cmd;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  en;
    } ui_cmd_s;

    // last marks the final beat of a write burst
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [MASK_WIDTH-1:0] mask;
        logic                  wren;
        logic                  last;
    } ui_wdf_s;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  valid;
        logic                  last;
    } ui_rd_s;

endpackage

`default_nettype wire

//--- dmc_replay.f
common/dmc_trace_pkg.sv
source/sync_fifo.sv
trace_replay/ui_trace_replay.sv
ui_mem_model/ui_mem_model.sv
source/dmc_replay_top.sv
verif/tb_dmc_replay.sv

//--- source/dmc_replay_top.sv
/*
  Trace replay engine joined to the controller model.
  The consumer may raise rd_yumi_i only while rd_v_o is high.
*/

`timescale 1ns/10ps
`default_nettype none

module dmc_replay_top
    import dmc_trace_pkg::*;
#(
    parameter int TFIFO_DEPTH  = 16,
    parameter int RFIFO_DEPTH  = 8,
    parameter int BURST_LEN    = 4,
    parameter int READ_LATENCY = 4,
    parameter int MEM_WORDS    = 1024
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,

    input  wire trace_entry_s          trace_data_i,
    input  wire logic                  trace_v_i,
    output      logic                  trace_ready_o,

    output      logic [DATA_WIDTH-1:0] rd_data_o,
    output      logic                  rd_v_o,
    input  wire logic                  rd_yumi_i
);

    ui_cmd_s ui_cmd;
    ui_wdf_s ui_wdf;
    ui_rd_s  ui_rd;
    logic    app_rdy;
    logic    app_wdf_rdy;

    ui_trace_replay #(
        .TFIFO_DEPTH (TFIFO_DEPTH),
        .RFIFO_DEPTH (RFIFO_DEPTH),
        .BURST_LEN   (BURST_LEN)
    ) replay0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .trace_data_i  (trace_data_i),
        .trace_v_i     (trace_v_i),
        .trace_ready_o (trace_ready_o),
        .rd_data_o     (rd_data_o),
        .rd_v_o        (rd_v_o),
        .rd_yumi_i     (rd_yumi_i),
        .ui_cmd_o      (ui_cmd),
        .app_rdy_i     (app_rdy),
        .ui_wdf_o      (ui_wdf),
        .app_wdf_rdy_i (app_wdf_rdy),
        .ui_rd_i       (ui_rd)
    );

    ui_mem_model #(
        .BURST_LEN    (BURST_LEN),
        .READ_LATENCY (READ_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) mem0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ui_cmd_i      (ui_cmd),
        .app_rdy_o     (app_rdy),
        .ui_wdf_i      (ui_wdf),
        .app_wdf_rdy_o (app_wdf_rdy),
        .ui_rd_o       (ui_rd)
    );

endmodule

`default_nettype wire

//--- source/sync_fifo.sv
/*
  Circular-buffer FIFO, DEPTH of 2 or more. yumi_i must only be raised
  while v_o is high. Pushes into a full FIFO are ignored.
*/

`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic             clk_i,
    input  wire logic             reset_i,

    input  wire logic [WIDTH-1:0] data_i,
    input  wire logic             v_i,
    output      logic             ready_o,

    output      logic [WIDTH-1:0] data_o,
    output      logic             v_o,
    input  wire logic             yumi_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wptr_r;
    logic [PTR_W-1:0] rptr_r;
    logic [CNT_W-1:0] count_r;
    logic             push;
    logic             pop;

    assign ready_o = (count_r != CNT_W'(DEPTH));
    assign v_o     = (count_r != '0);
    assign push    = v_i & ready_o;
    assign pop     = yumi_i & v_o;
    assign data_o  = mem[rptr_r];

    // Storage array
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wptr_r] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wptr_r  <= '0;
            rptr_r  <= '0;
            count_r <= '0;
        end else begin
            if (push) begin
                // Explicit wrap, DEPTH need not be a power of two
                wptr_r <= (wptr_r == PTR_W'(DEPTH - 1)) ? '0 : wptr_r + 1'b1;
            end
            if (pop) begin
                rptr_r <= (rptr_r == PTR_W'(DEPTH - 1)) ? '0 : rptr_r + 1'b1;
            end
            if (push && !pop) begin
                count_r <= count_r + 1'b1;
            end else if (pop && !push) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- trace_replay/ui_trace_replay.sv
/*
  Collects trace entries until TEX, then drains them onto the controller UI.
  A trace FIFO that fills before TEX arrives blocks until reset.
*/

`timescale 1ns/10ps
`default_nettype none

module ui_trace_replay
    import dmc_trace_pkg::*;
#(
    parameter int TFIFO_DEPTH = 16,
    parameter int RFIFO_DEPTH = 8,
    parameter int BURST_LEN   = 4
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,

    // Trace entries from the producer
    input  wire trace_entry_s          trace_data_i,
    input  wire logic                  trace_v_i,
    output      logic                  trace_ready_o,

    // Read beats to the consumer
    output      logic [DATA_WIDTH-1:0] rd_data_o,
    output      logic                  rd_v_o,
    input  wire logic                  rd_yumi_i,

    // Controller user interface
    output      ui_cmd_s               ui_cmd_o,
    input  wire logic                  app_rdy_i,
    output      ui_wdf_s               ui_wdf_o,
    input  wire logic                  app_wdf_rdy_i,
    input  wire ui_rd_s                ui_rd_i
);

    localparam int CREDIT_W = $clog2(RFIFO_DEPTH + 1);

    typedef enum logic {
        REPLAY_FILL,
        REPLAY_DRAIN
    } replay_state_e;

    replay_state_e state_r;
    replay_state_e state_n;

    trace_entry_s         head;
    logic                 tf_v_in;
    logic                 tf_ready;
    logic                 tf_v_out;
    logic                 tf_yumi;
    logic [CREDIT_W-1:0]  credit_r;
    logic                 read_avail;
    logic                 rd_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Trace and read-return buffers
    ////////////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .WIDTH ($bits(trace_entry_s)),
        .DEPTH (TFIFO_DEPTH)
    ) trace_fifo0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (trace_data_i),
        .v_i     (tf_v_in),
        .ready_o (tf_ready),
        .data_o  (head),
        .v_o     (tf_v_out),
        .yumi_i  (tf_yumi)
    );

    // Room is guaranteed by the credit count
    sync_fifo #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (RFIFO_DEPTH)
    ) read_fifo0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (ui_rd_i.data),
        .v_i     (ui_rd_i.valid),
        .ready_o (),
        .data_o  (rd_data_o),
        .v_o     (rd_v_o),
        .yumi_i  (rd_yumi_i)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Head decode and drain control
    ////////////////////////////////////////////////////////////////////////////

    wire is_write = head.app_cmd inside {WR, WP};
    wire is_read  = head.app_cmd inside {RD, RP};
    wire is_wdata = head.app_cmd inside {TWD, TWT};
    // TNP, and any stray code, retires without action
    wire is_skip  = !(is_write || is_read || is_wdata);

    assign read_avail = (credit_r >= CREDIT_W'(BURST_LEN));
    assign rd_accept  = ui_cmd_o.en & app_rdy_i & is_read;

    always_comb begin
        state_n        = state_r;
        trace_ready_o  = 1'b0;
        tf_v_in        = 1'b0;
        tf_yumi        = 1'b0;

        ui_cmd_o.cmd   = head.app_cmd;
        ui_cmd_o.addr  = head.payload.cmd.addr;
        ui_cmd_o.en    = 1'b0;
        ui_wdf_o.data  = head.payload.wdata.data;
        ui_wdf_o.mask  = head.payload.wdata.mask;
        ui_wdf_o.wren  = 1'b0;
        ui_wdf_o.last  = 1'b0;

        case (state_r)
            REPLAY_FILL: begin
                trace_ready_o = tf_ready;
                tf_v_in = trace_v_i & (trace_data_i.app_cmd != TEX);
                if (trace_v_i && tf_ready && trace_data_i.app_cmd == TEX) begin
                    state_n = REPLAY_DRAIN;
                end
            end
            REPLAY_DRAIN: begin
                ui_cmd_o.en   = tf_v_out & (is_write | (is_read & read_avail));
                ui_wdf_o.wren = tf_v_out & is_wdata;
                ui_wdf_o.last = tf_v_out & (head.app_cmd == TWT);
                tf_yumi = tf_v_out & ((ui_cmd_o.en & app_rdy_i)
                                    | (ui_wdf_o.wren & app_wdf_rdy_i)
                                    | is_skip);
                // Back to fill once everything has gone out
                if (!tf_v_out) begin
                    state_n = REPLAY_FILL;
                end
            end
            default: begin
                state_n = REPLAY_FILL;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= REPLAY_FILL;
        end else begin
            state_r <= state_n;
        end
    end

    // Free read-buffer slots
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credit_r <= CREDIT_W'(RFIFO_DEPTH);
        end else begin
            credit_r <= credit_r
                      - (rd_accept ? CREDIT_W'(BURST_LEN) : '0)
                      + (rd_yumi_i ? CREDIT_W'(1) : '0);
        end
    end

endmodule

`default_nettype wire

//--- ui_mem_model/ui_mem_model.sv
/*
  Controller stand-in without DRAM timing. MEM_WORDS is a power of two, at most
  2**ADDR_WIDTH; upper address bits are ignored. READ_LATENCY must be 1 or more.
*/

`timescale 1ns/10ps
`default_nettype none

module ui_mem_model
    import dmc_trace_pkg::*;
#(
    parameter int BURST_LEN    = 4,
    parameter int READ_LATENCY = 4,
    parameter int MEM_WORDS    = 1024
) (
    input  wire logic    clk_i,
    input  wire logic    reset_i,

    input  wire ui_cmd_s ui_cmd_i,
    output      logic    app_rdy_o,
    input  wire ui_wdf_s ui_wdf_i,
    output      logic    app_wdf_rdy_o,
    output      ui_rd_s  ui_rd_o
);

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int BEAT_W = $clog2(BURST_LEN + 1);
    localparam int LAT_W  = $clog2(READ_LATENCY + 1);

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WDATA,
        MEM_RWAIT,
        MEM_RBURST
    } mem_state_e;

    mem_state_e state_r;

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [ADDR_WIDTH-1:0] addr_r;
    logic [MEM_AW-1:0]     idx;
    logic [BEAT_W-1:0]     beat_cnt_r;
    logic [LAT_W-1:0]      lat_cnt_r;
    logic                  cmd_fire;
    logic                  cmd_is_write;
    logic                  cmd_is_read;
    logic                  wbeat;
    logic                  last_rbeat;

    assign idx = addr_r[MEM_AW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////

    // Precharge variants behave as plain accesses
    assign cmd_is_write = ui_cmd_i.cmd inside {WR, WP};
    assign cmd_is_read  = ui_cmd_i.cmd inside {RD, RP};

    assign app_rdy_o     = (state_r == MEM_IDLE);
    assign app_wdf_rdy_o = (state_r == MEM_IDLE) || (state_r == MEM_WDATA);
    assign cmd_fire      = ui_cmd_i.en & app_rdy_o;

    // Beats only land inside a write burst; stray idle beats are dropped
    assign wbeat = (state_r == MEM_WDATA) & ui_wdf_i.wren;

    assign last_rbeat    = (beat_cnt_r == BEAT_W'(BURST_LEN - 1));
    assign ui_rd_o.data  = mem[idx];
    assign ui_rd_o.valid = (state_r == MEM_RBURST);
    assign ui_rd_o.last  = (state_r == MEM_RBURST) & last_rbeat;

    ////////////////////////////////////////////////////////////////////////////
    // Memory array
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wbeat) begin
            for (int b = 0; b < MASK_WIDTH; b++) begin
                if (ui_wdf_i.mask[b]) begin
                    mem[idx][8*b +: 8] <= ui_wdf_i.data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Burst sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r    <= MEM_IDLE;
            addr_r     <= '0;
            beat_cnt_r <= '0;
            lat_cnt_r  <= '0;
        end else begin
            case (state_r)
                MEM_IDLE: begin
                    beat_cnt_r <= '0;
                    // Acceptance cycle counts as latency cycle 0
                    lat_cnt_r  <= LAT_W'(1);
                    if (cmd_fire) begin
                        addr_r <= ui_cmd_i.addr;
                        if (cmd_is_write) begin
                            state_r <= MEM_WDATA;
                        end else if (cmd_is_read) begin
                            state_r <= (READ_LATENCY <= 1) ? MEM_RBURST : MEM_RWAIT;
                        end
                    end
                end
                MEM_WDATA: begin
                    if (wbeat) begin
                        addr_r <= addr_r + 1'b1;
                        if (ui_wdf_i.last) begin
                            state_r <= MEM_IDLE;
                        end
                    end
                end
                MEM_RWAIT: begin
                    lat_cnt_r <= lat_cnt_r + 1'b1;
                    if (lat_cnt_r >= LAT_W'(READ_LATENCY - 1)) begin
                        state_r <= MEM_RBURST;
                    end
                end
                MEM_RBURST: begin
                    addr_r     <= addr_r + 1'b1;
                    beat_cnt_r <= beat_cnt_r + 1'b1;
                    // Ready returns the cycle after the end beat
                    if (last_rbeat) begin
                        state_r <= MEM_IDLE;
                    end
                end
                default: begin
                    state_r <= MEM_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dmc_replay.sv
/*
  Directed tests for dmc_replay_top. The controller model memory starts out
  undefined, so every read targets words that an earlier write filled.
*/

`timescale 1ns/10ps
`default_nettype none

module tb_dmc_replay
    import dmc_trace_pkg::*;
();

    localparam int TFIFO_DEPTH     = 16;
    localparam int RFIFO_DEPTH     = 8;
    localparam int BURST_LEN       = 4;
    localparam int READ_LATENCY    = 4;
    localparam int MEM_WORDS       = 1024;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int WAIT_LIMIT      = 1000;
    localparam logic [31:0] LFSR_SEED = 32'he90c_ac37;

    logic                  clk_i;
    logic                  reset_i;
    trace_entry_s          trace_data_i;
    logic                  trace_v_i;
    logic                  trace_ready_o;
    logic [DATA_WIDTH-1:0] rd_data_o;
    logic                  rd_v_o;
    logic                  rd_yumi_i;

    // Reference memory and per-trace bookkeeping
    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic                  ref_valid [MEM_WORDS];
    trace_entry_s          trace_q [$];
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [DATA_WIDTH-1:0] got_q [$];
    logic [ADDR_WIDTH-1:0] bases [$];
    logic [31:0]           lfsr_q = LFSR_SEED;
    logic                  consumer_hold;
    int                    errors = 0;

    dmc_replay_top #(
        .TFIFO_DEPTH  (TFIFO_DEPTH),
        .RFIFO_DEPTH  (RFIFO_DEPTH),
        .BURST_LEN    (BURST_LEN),
        .READ_LATENCY (READ_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) dut0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .trace_data_i  (trace_data_i),
        .trace_v_i     (trace_v_i),
        .trace_ready_o (trace_ready_o),
        .rd_data_o     (rd_data_o),
        .rd_v_o        (rd_v_o),
        .rd_yumi_i     (rd_yumi_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois form with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic trace_entry_s cmd_entry(input app_cmd_e c,
                                               input logic [ADDR_WIDTH-1:0] a);
        trace_entry_s e;
        e.app_cmd          = c;
        e.payload.cmd.pad  = '0;
        e.payload.cmd.addr = a;
        return e;
    endfunction

    function automatic trace_entry_s data_entry(input app_cmd_e c,
                                                input logic [DATA_WIDTH-1:0] d,
                                                input logic [MASK_WIDTH-1:0] m);
        trace_entry_s e;
        e.app_cmd            = c;
        e.payload.wdata.data = d;
        e.payload.wdata.mask = m;
        return e;
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic apply_reset();
        reset_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset trace_ready_o", 32'd1, 32'(trace_ready_o));
        check_value("reset rd_v_o", 32'd0, 32'(rd_v_o));
    endtask

    // Queue a write burst and merge it into the reference by byte enable
    task automatic add_write(input app_cmd_e cmd, input logic [ADDR_WIDTH-1:0] base,
                             input logic [BURST_LEN*DATA_WIDTH-1:0] data,
                             input logic [BURST_LEN*MASK_WIDTH-1:0] mask);
        logic [ADDR_WIDTH-1:0] w;
        logic [DATA_WIDTH-1:0] d;
        logic [MASK_WIDTH-1:0] m;
        trace_q.push_back(cmd_entry(cmd, base));
        for (int i = 0; i < BURST_LEN; i++) begin
            w = base + ADDR_WIDTH'(i);
            d = data[i*DATA_WIDTH +: DATA_WIDTH];
            m = mask[i*MASK_WIDTH +: MASK_WIDTH];
            if (i == BURST_LEN - 1) begin
                trace_q.push_back(data_entry(TWT, d, m));
            end else begin
                trace_q.push_back(data_entry(TWD, d, m));
            end
            for (int b = 0; b < MASK_WIDTH; b++) begin
                if (m[b]) begin
                    ref_mem[w][8*b +: 8] = d[8*b +: 8];
                end
            end
            if (m == '1) begin
                ref_valid[w] = 1'b1;
            end
        end
        bases.push_back(base);
    endtask

    task automatic add_read(input app_cmd_e cmd, input logic [ADDR_WIDTH-1:0] base);
        trace_q.push_back(cmd_entry(cmd, base));
        for (int i = 0; i < BURST_LEN; i++) begin
            exp_q.push_back(ref_mem[base + ADDR_WIDTH'(i)]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Producer side
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_entry(input trace_entry_s e);
        int waited;
        waited = 0;
        @(posedge clk_i);
        trace_data_i <= e;
        trace_v_i    <= 1'b1;
        @(negedge clk_i);
        while (!trace_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: trace_ready_o stayed low for %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            @(negedge clk_i);
        end
        // Transfer happens on this edge
        @(posedge clk_i);
        trace_v_i <= 1'b0;
    endtask

    task automatic send_entries();
        for (int i = 0; i < trace_q.size(); i++) begin
            send_entry(trace_q[i]);
        end
    endtask

    task automatic send_execute();
        send_entry(cmd_entry(TEX, '0));
    endtask

    task automatic wait_drain(input string test);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!trace_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: drain in %s did not return to fill", test);
                abort_run();
            end
            @(negedge clk_i);
        end
    endtask

    task automatic wait_beats(input string test, input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n) begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: %s got %0d of %0d read beats", test, got_q.size(), n);
                abort_run();
            end
        end
    endtask

    task automatic finish_trace(input string test);
        wait_drain(test);
        wait_beats(test, exp_q.size());
        // Settle time to catch stray beats
        repeat (10) @(posedge clk_i);
        check_value({test, " beat count"}, 32'(exp_q.size()), 32'(got_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value(test, exp_q[i], got_q[i]);
        end
        trace_q.delete();
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic run_trace(input string test);
        send_entries();
        send_execute();
        finish_trace(test);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Consumer side with LFSR stalls and one-cycle yumi pulses
    ////////////////////////////////////////////////////////////////////////////

    initial begin : consume_beats
        logic [31:0] bit_val;
        rd_yumi_i <= 1'b0;
        forever begin
            @(negedge clk_i);
            if (rd_v_o && !consumer_hold && !reset_i) begin
                bit_val = random_bits(1);
                if (bit_val[0]) begin
                    got_q.push_back(rd_data_o);
                    @(posedge clk_i);
                    rd_yumi_i <= 1'b1;
                    @(posedge clk_i);
                    rd_yumi_i <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_write_read();
        @(posedge clk_i);
        add_write(WR, 10'h010, {32'hc0de_0003, 32'hc0de_0002, 32'hc0de_0001,
                                32'hc0de_0000}, '1);
        add_read(RD, 10'h010);
        run_trace("write_read");
    endtask

    task automatic test_fill_hold();
        @(posedge clk_i);
        add_write(WP, 10'h0a0, {32'h0bad_f00d, 32'h1234_5678, 32'h9abc_def0,
                                32'hfeed_beef}, '1);
        add_read(RD, 10'h0a0);
        send_entries();
        // Nothing may run before TEX
        repeat (20) begin
            @(negedge clk_i);
            check_value("fill_hold rd_v_o", 32'd0, 32'(rd_v_o));
            check_value("fill_hold trace_ready_o", 32'd1, 32'(trace_ready_o));
        end
        send_execute();
        finish_trace("fill_hold");
    endtask

    task automatic test_masked_write();
        @(posedge clk_i);
        add_write(WR, 10'h040, {32'h8899_aabb, 32'hccdd_eeff, 32'h0011_2233,
                                32'h4455_6677}, '1);
        add_write(WR, 10'h040, {32'h1122_3344, 32'h5566_7788, 32'h99aa_bbcc,
                                32'hddee_ff00}, {4'b0101, 4'b1000, 4'b0110, 4'b0001});
        add_read(RP, 10'h040);
        run_trace("masked_write");
    endtask

    task automatic test_nop_backpressure();
        @(posedge clk_i);
        trace_q.push_back(cmd_entry(TNP, '0));
        add_write(WR, 10'h080, {32'h0808_0003, 32'h0808_0002, 32'h0808_0001,
                                32'h0808_0000}, '1);
        trace_q.push_back(cmd_entry(TNP, '0));
        add_read(RD, 10'h080);
        trace_q.push_back(cmd_entry(TNP, '0));
        run_trace("nop_drain");

        // Four bursts outstanding against room for two
        consumer_hold = 1'b1;
        add_read(RD, 10'h010);
        add_read(RP, 10'h040);
        add_read(RD, 10'h080);
        add_read(RP, 10'h0a0);
        send_entries();
        send_execute();
        repeat (60) @(posedge clk_i);
        @(negedge clk_i);
        check_value("backpressure trace_ready_o", 32'd0, 32'(trace_ready_o));
        check_value("backpressure rd_v_o", 32'd1, 32'(rd_v_o));
        @(posedge clk_i);
        consumer_hold = 1'b0;
        finish_trace("backpressure");
    endtask

    task automatic test_full_fifo();
        for (int i = 0; i < TFIFO_DEPTH; i++) begin
            send_entry(cmd_entry(TNP, '0));
            @(negedge clk_i);
            check_value("full_fifo trace_ready_o", (i < TFIFO_DEPTH - 1) ? 32'd1 : 32'd0,
                        32'(trace_ready_o));
        end
        // A full FIFO cannot take TEX, only reset clears it
        apply_reset();
    endtask

    task automatic test_random_mix();
        logic [ADDR_WIDTH-1:0]           base;
        logic [ADDR_WIDTH-1:0]           w;
        logic [BURST_LEN*DATA_WIDTH-1:0] data;
        logic [BURST_LEN*MASK_WIDTH-1:0] mask;
        int                              idx;
        @(posedge clk_i);
        for (int op = 0; op < 20; op++) begin
            if (bases.size() == 0 || random_bits(1) == 32'd1) begin
                // TEX needs one free slot
                if (trace_q.size() + BURST_LEN + 1 > TFIFO_DEPTH - 1) begin
                    run_trace("random_mix");
                end
                base = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                for (int i = 0; i < BURST_LEN; i++) begin
                    w = base + ADDR_WIDTH'(i);
                    data[i*DATA_WIDTH +: DATA_WIDTH] = random_bits(DATA_WIDTH);
                    mask[i*MASK_WIDTH +: MASK_WIDTH] =
                        ref_valid[w] ? MASK_WIDTH'(random_bits(MASK_WIDTH)) : '1;
                end
                if (random_bits(1) == 32'd1) begin
                    add_write(WP, base, data, mask);
                end else begin
                    add_write(WR, base, data, mask);
                end
            end else begin
                if (trace_q.size() + 1 > TFIFO_DEPTH - 1) begin
                    run_trace("random_mix");
                end
                idx = int'(random_bits(4)) % bases.size();
                add_read(RD, bases[idx]);
            end
        end
        if (trace_q.size() != 0) begin
            run_trace("random_mix");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset_i       <= 1'b1;
        trace_data_i  <= '0;
        trace_v_i     <= 1'b0;
        consumer_hold = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_valid[i] = 1'b0;
        end
        apply_reset();

        test_write_read();
        test_fill_hold();
        test_masked_write();
        test_nop_backpressure();
        test_full_fifo();
        test_random_mix();

        if (errors == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin : watchdog
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk_i);
        $display("Timeout: tests did not finish within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        abort_run();
    end

endmodule

`default_nettype wire
